// File: Bender.yml
package:
  name: beamscaler

sources:
  - include_dirs:
      - source
    files:
      - source/beamscaler_pkg.sv
      - source/scaler_interval_fsm.sv
      - source/scaler_counter_bank.sv
      - source/scaler_readout_store.sv
      - source/beamscaler_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verif/beamscaler_checker.sv
      - verif/beamscaler_tb.sv

// File: filelist.f
+incdir+source
source/beamscaler_pkg.sv
source/scaler_interval_fsm.sv
source/scaler_counter_bank.sv
source/scaler_readout_store.sv
source/beamscaler_top.sv
verif/beamscaler_checker.sv
verif/beamscaler_tb.sv

// File: source/beamscaler_defs.svh
`ifndef BEAMSCALER_DEFS_SVH
`define BEAMSCALER_DEFS_SVH

// number of beams, each with two threshold discriminators
`define BS_NBEAMS 6

// count channels: channel 2b is beam b thr 0, channel 2b+1 is beam b thr 1
`define BS_NCHAN (2*`BS_NBEAMS)

// scaler width, counters stop at all ones
`define BS_SCAL_W 16

// host read port
`define BS_ADR_W 8
`define BS_STATUS_ADR 255   // status word location

`endif

// File: source/beamscaler_pkg.sv
`include "beamscaler_defs.svh"

package beamscaler_pkg;

    // one scaler value
    typedef logic [`BS_SCAL_W-1:0] scal_count_t;

    // interval FSM states
    typedef enum logic [1:0] {
        IDLE  = 2'd0,   // waiting for first timer pulse
        COUNT = 2'd1,   // interval open
        LATCH = 2'd2    // interval closed, snapshot pending
    } interval_state_e;

    // controls from the FSM to counters and store
    typedef struct packed {
        logic count_en;   // count this cycle
        logic clear;      // zero counters and sat flags
        logic latch;      // copy snapshot into store
    } interval_ctrl_t;

    // live counter values handed to the readout store
    typedef struct packed {
        scal_count_t [`BS_NCHAN-1:0] count;
        logic [`BS_NCHAN-1:0]        sat;
    } count_snapshot_t;

    // beam word, thr 1 in the upper half
    typedef struct packed {
        scal_count_t thr1;
        scal_count_t thr0;
    } beam_pair_t;

    // status word at BS_STATUS_ADR
    typedef struct packed {
        logic [15:0]          interval_num;   // completed intervals, wraps
        logic [3:0]           rsvd;           // always zero
        logic [`BS_NCHAN-1:0] sat;
    } status_word_t;

    // the read data word, decoded by address
    typedef union packed {
        beam_pair_t   pair;
        status_word_t status;
        logic [31:0]  raw;
    } readout_word_u;

endpackage

// File: source/beamscaler_top.sv
`timescale 1ns/1ps
`include "beamscaler_defs.svh"

module beamscaler_top
    import beamscaler_pkg::*;
(
    input  logic                 ifclk,
    input  logic                 arst_n_i,
    input  logic [`BS_NCHAN-1:0] count_i,
    input  logic                 timer_i,
    output logic                 done_o,
    input  logic                 scal_rd_i,
    input  logic [`BS_ADR_W-1:0] scal_adr_i,
    output logic [31:0]          scal_dat_o
);

    interval_ctrl_t  ctrl;       // FSM to counters and store
    count_snapshot_t snapshot;   // live counts to the store

    // interval sequencing from the external timer pulse
    scaler_interval_fsm i_scaler_interval_fsm (
        .ifclk    (ifclk),
        .arst_n_i (arst_n_i),
        .timer_i  (timer_i),
        .ctrl_o   (ctrl),
        .done_o   (done_o)
    );

    // per-channel high-cycle counters
    scaler_counter_bank i_scaler_counter_bank (
        .ifclk      (ifclk),
        .arst_n_i   (arst_n_i),
        .count_i    (count_i),
        .ctrl_i     (ctrl),
        .snapshot_o (snapshot)
    );

    // frozen results and host read path
    scaler_readout_store i_scaler_readout_store (
        .ifclk      (ifclk),
        .arst_n_i   (arst_n_i),
        .ctrl_i     (ctrl),
        .snapshot_i (snapshot),
        .scal_rd_i  (scal_rd_i),
        .scal_adr_i (scal_adr_i),
        .scal_dat_o (scal_dat_o)
    );

endmodule

// File: source/scaler_counter_bank.sv
`timescale 1ns/1ps
`include "beamscaler_defs.svh"

module scaler_counter_bank
    import beamscaler_pkg::*;
(
    input  logic                  ifclk,
    input  logic                  arst_n_i,
    input  logic [`BS_NCHAN-1:0]  count_i,
    input  interval_ctrl_t        ctrl_i,
    output count_snapshot_t       snapshot_o
);

    localparam scal_count_t SCAL_MAX = '1;

    scal_count_t [`BS_NCHAN-1:0] cnt_q;   // one counter per channel
    logic [`BS_NCHAN-1:0]        sat_q;   // sticky until the next clear

    // saturating high-cycle counters
    always_ff @(posedge ifclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_q <= '0;
            sat_q <= '0;
        end else if (ctrl_i.clear) begin
            cnt_q <= '0;
            sat_q <= '0;
        end else if (ctrl_i.count_en) begin
            for (int c = 0; c < `BS_NCHAN; c++) begin
                if (count_i[c] && (cnt_q[c] != SCAL_MAX)) begin
                    cnt_q[c] <= cnt_q[c] + 1'b1;
                end
                // flag as soon as the counter reaches all ones
                if (count_i[c] && (cnt_q[c] >= SCAL_MAX - 1'b1)) begin
                    sat_q[c] <= 1'b1;
                end
            end
        end
    end

    assign snapshot_o.count = cnt_q;
    assign snapshot_o.sat   = sat_q;

    // counters only move while the FSM has an interval open
    property p_hold_when_disabled;
        @(posedge ifclk) disable iff (!arst_n_i)
            (!ctrl_i.count_en && !ctrl_i.clear) |=> ($stable(cnt_q) && $stable(sat_q));
    endproperty
    a_hold_when_disabled: assert property (p_hold_when_disabled)
        else $error("counter changed outside an open interval");

endmodule

// File: source/scaler_interval_fsm.sv
`timescale 1ns/1ps
`include "beamscaler_defs.svh"

module scaler_interval_fsm
    import beamscaler_pkg::*;
(
    input  logic           ifclk,
    input  logic           arst_n_i,
    input  logic           timer_i,
    output interval_ctrl_t ctrl_o,
    output logic           done_o
);

    interval_state_e state_q;
    interval_state_e state_d;
    logic            done_q;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (timer_i) state_d = COUNT;   // first pulse opens an interval
            end
            COUNT: begin
                if (timer_i) state_d = LATCH;   // closing pulse
            end
            LATCH: begin
                state_d = COUNT;   // timer ignored here
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    // controls are decoded straight from state and the timer
    // so the closing edge itself is not counted
    always_comb begin
        ctrl_o.count_en = (state_q == COUNT) && !timer_i;
        ctrl_o.clear    = ((state_q == IDLE) && timer_i) || (state_q == LATCH);
        ctrl_o.latch    = (state_q == LATCH);
    end

    always_ff @(posedge ifclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= ctrl_o.latch;   // one cycle behind the latch
        end
    end

    assign done_o = done_q;

    // a latch always returns to COUNT, never back to back
    property p_latch_single;
        @(posedge ifclk) disable iff (!arst_n_i)
            ctrl_o.latch |=> !ctrl_o.latch;
    endproperty
    a_latch_single: assert property (p_latch_single)
        else $error("latch asserted on two consecutive cycles");

    // done is exactly the latch delayed by one cycle
    property p_done_after_latch;
        @(posedge ifclk) disable iff (!arst_n_i)
            ##1 (done_o == $past(ctrl_o.latch));
    endproperty
    a_done_after_latch: assert property (p_done_after_latch)
        else $error("done_o does not follow latch by one cycle");

endmodule

// File: source/scaler_readout_store.sv
`timescale 1ns/1ps
`include "beamscaler_defs.svh"

module scaler_readout_store
    import beamscaler_pkg::*;
(
    input  logic                 ifclk,
    input  logic                 arst_n_i,
    input  interval_ctrl_t       ctrl_i,
    input  count_snapshot_t      snapshot_i,
    input  logic                 scal_rd_i,
    input  logic [`BS_ADR_W-1:0] scal_adr_i,
    output logic [31:0]          scal_dat_o
);

    count_snapshot_t      snap_q;   // frozen counts of the last interval
    logic [15:0]          num_q;    // completed interval number

    beam_pair_t           pair_sel;
    status_word_t         status_sel;

    // stage one
    logic                 rd_q1;
    logic [`BS_ADR_W-1:0] adr_q1;
    beam_pair_t           pair_q1;
    status_word_t         status_q1;

    // stage two
    readout_word_u        word_d;
    readout_word_u        word_q2;
    logic                 rd_q2;

    logic [31:0]          dat_q;

    // snapshot store and interval number
    always_ff @(posedge ifclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            snap_q <= '0;
            num_q  <= '0;
        end else if (ctrl_i.latch) begin
            snap_q <= snapshot_i;
            num_q  <= num_q + 1'b1;   // wraps
        end
    end

    // pick the addressed beam from the store
    always_comb begin
        pair_sel = '0;
        for (int b = 0; b < `BS_NBEAMS; b++) begin
            if (scal_adr_i == `BS_ADR_W'(b)) begin
                pair_sel.thr0 = snap_q.count[2*b];
                pair_sel.thr1 = snap_q.count[2*b+1];
            end
        end
    end

    always_comb begin
        status_sel.interval_num = num_q;
        status_sel.rsvd         = '0;
        status_sel.sat          = snap_q.sat;
    end

    // data is taken at the strobe edge, so a read on the latch edge
    // still sees the previous snapshot
    always_ff @(posedge ifclk) begin
        if (scal_rd_i) begin
            adr_q1    <= scal_adr_i;
            pair_q1   <= pair_sel;
            status_q1 <= status_sel;
        end
    end

    // address decode into the readout word
    always_comb begin
        if (adr_q1 < `BS_ADR_W'(`BS_NBEAMS)) begin
            word_d.pair = pair_q1;
        end else if (adr_q1 == `BS_ADR_W'(`BS_STATUS_ADR)) begin
            word_d.status = status_q1;
        end else begin
            word_d.raw = '0;   // unmapped
        end
    end

    always_ff @(posedge ifclk) begin
        if (rd_q1) word_q2 <= word_d;
    end

    // strobe pipeline and output register
    always_ff @(posedge ifclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_q1 <= 1'b0;
            rd_q2 <= 1'b0;
            dat_q <= '0;
        end else begin
            rd_q1 <= scal_rd_i;
            rd_q2 <= rd_q1;
            if (rd_q2) dat_q <= word_q2.raw;   // held until the next read lands
        end
    end

    assign scal_dat_o = dat_q;

endmodule

// File: verif/beamscaler_checker.sv
`timescale 1ns/1ps
`include "beamscaler_defs.svh"

module beamscaler_checker (
    input  logic                 ifclk,
    input  logic                 arst_n_i,
    input  logic [`BS_NCHAN-1:0] count_i,
    input  logic                 timer_i,
    input  logic                 done_i,
    input  logic                 scal_rd_i,
    input  logic [`BS_ADR_W-1:0] scal_adr_i,
    input  logic [31:0]          scal_dat_i,
    input  logic [3:0]           test_num_i,
    input  logic                 test_end_i,
    output int                   tests_pass_o,
    output int                   tests_fail_o,
    output int                   err_total_o
);

    localparam int ST_IDLE  = 0;
    localparam int ST_COUNT = 1;
    localparam int ST_LATCH = 2;

    // interval model
    int                   m_state;
    logic [`BS_SCAL_W-1:0] m_cnt [`BS_NCHAN];
    logic [`BS_SCAL_W-1:0] m_snap [`BS_NCHAN];
    logic [`BS_NCHAN-1:0] m_sat;
    logic [`BS_NCHAN-1:0] m_snap_sat;
    logic [15:0]          m_num;
    logic                 m_done;

    // read pipeline model, words are fixed at the strobe edge
    logic                 p1_v;
    logic                 p2_v;
    logic                 land;
    logic [31:0]          p1_w;
    logic [31:0]          p2_w;
    logic [31:0]          m_dat;
    logic [`BS_ADR_W-1:0] p1_adr;
    logic [`BS_ADR_W-1:0] p2_adr;
    logic [`BS_ADR_W-1:0] land_adr;

    int test_checks;
    int test_errs;

    function automatic string test_name(input logic [3:0] n);
        case (n)
            1: return "ignore_before_first_pulse";
            2: return "single_interval";
            3: return "done_and_interval_number";
            4: return "back_to_back_clear";
            5: return "saturation";
            6: return "unmapped_reads";
            default: return "setup";
        endcase
    endfunction

    // beam words hold thr 1 above thr 0, the status word sits at the top address
    function automatic logic [31:0] expected_word(input logic [`BS_ADR_W-1:0] adr);
        logic [31:0] w;
        w = '0;
        if (adr < `BS_NBEAMS) begin
            w = {m_snap[2*adr+1], m_snap[2*adr]};
        end else if (adr == `BS_STATUS_ADR) begin
            w = {m_num, 4'b0000, m_snap_sat};
        end
        return w;
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("FAIL %s: %s expected %h actual %h", test_name(test_num_i), what, exp, act);
        test_errs++;
        err_total_o++;
    endtask

    task automatic clear_counts();
        for (int c = 0; c < `BS_NCHAN; c++) m_cnt[c] = '0;
        m_sat = '0;
    endtask

    task automatic reset_model();
        clear_counts();
        for (int c = 0; c < `BS_NCHAN; c++) m_snap[c] = '0;
        m_state     = ST_IDLE;
        m_snap_sat  = '0;
        m_num       = '0;
        m_done      = 1'b0;
        p1_v        = 1'b0;
        p2_v        = 1'b0;
        land        = 1'b0;
        m_dat       = '0;
        test_checks = 0;
        test_errs   = 0;
        tests_pass_o = 0;
        tests_fail_o = 0;
        err_total_o  = 0;
    endtask

    task automatic check_outputs();
        if (land) begin
            test_checks++;
            if (scal_dat_i !== m_dat) begin
                report_mismatch($sformatf("read of address %0d", land_adr), m_dat, scal_dat_i);
            end
        end
        if (m_done || done_i) test_checks++;
        if (done_i !== m_done) report_mismatch("done_o", {31'b0, m_done}, {31'b0, done_i});
    endtask

    task automatic step_read_pipe();
        land     = p2_v;
        land_adr = p2_adr;
        if (p2_v) m_dat = p2_w;   // shows from R+2 on
        p2_v   = p1_v;
        p2_w   = p1_w;
        p2_adr = p1_adr;
        p1_v   = scal_rd_i;
        if (scal_rd_i) begin
            p1_w   = expected_word(scal_adr_i);   // store before any latch this edge
            p1_adr = scal_adr_i;
        end
    endtask

    task automatic step_interval();
        m_done = 1'b0;
        case (m_state)
            ST_IDLE: begin
                if (timer_i) begin
                    clear_counts();
                    m_state = ST_COUNT;
                end
            end
            ST_COUNT: begin
                if (timer_i) begin
                    m_state = ST_LATCH;   // closing edge not counted
                end else begin
                    for (int c = 0; c < `BS_NCHAN; c++) begin
                        if (count_i[c] && m_cnt[c] != '1) m_cnt[c] = m_cnt[c] + 1'b1;
                        if (m_cnt[c] == '1) m_sat[c] = 1'b1;
                    end
                end
            end
            default: begin
                for (int c = 0; c < `BS_NCHAN; c++) m_snap[c] = m_cnt[c];
                m_snap_sat = m_sat;
                m_num      = m_num + 1'b1;
                clear_counts();
                m_done  = 1'b1;
                m_state = ST_COUNT;
            end
        endcase
    endtask

    task automatic finish_test();
        if (test_checks == 0) begin
            $display("test %0d %s: nothing was checked", test_num_i, test_name(test_num_i));
            tests_fail_o++;
        end else if (test_errs == 0) begin
            $display("test %0d %s: ok, %0d checks", test_num_i, test_name(test_num_i),
                     test_checks);
            tests_pass_o++;
        end else begin
            $display("test %0d %s: %0d of %0d checks wrong", test_num_i,
                     test_name(test_num_i), test_errs, test_checks);
            tests_fail_o++;
        end
        test_checks = 0;
        test_errs   = 0;
    endtask

    // inputs seen here are the values the DUT samples on the same edge
    always @(posedge ifclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            reset_model();
        end else begin
            check_outputs();
            step_read_pipe();
            step_interval();
            if (test_end_i) finish_test();
        end
    end

endmodule

// File: verif/beamscaler_tb.sv
`timescale 1ns/1ps
`include "beamscaler_defs.svh"

module beamscaler_tb;

    localparam int SAT_HOLD_CYCLES = 70000;
    // the saturation hold dominates, all other tests add a few thousand cycles
    localparam int TIMEOUT_CYCLES  = SAT_HOLD_CYCLES + 30000;

    logic                 ifclk;
    logic                 arst_n_i;
    logic [`BS_NCHAN-1:0] count_i;
    logic                 timer_i;
    logic                 done_o;
    logic                 scal_rd_i;
    logic [`BS_ADR_W-1:0] scal_adr_i;
    logic [31:0]          scal_dat_o;

    logic [3:0] test_num;
    logic       test_end;
    int         tests_pass;
    int         tests_fail;
    int         err_total;
    int         tb_errs;
    int         seed;
    int         cycles;

    beamscaler_top i_beamscaler_top (
        .ifclk      (ifclk),
        .arst_n_i   (arst_n_i),
        .count_i    (count_i),
        .timer_i    (timer_i),
        .done_o     (done_o),
        .scal_rd_i  (scal_rd_i),
        .scal_adr_i (scal_adr_i),
        .scal_dat_o (scal_dat_o)
    );

    beamscaler_checker i_beamscaler_checker (
        .ifclk        (ifclk),
        .arst_n_i     (arst_n_i),
        .count_i      (count_i),
        .timer_i      (timer_i),
        .done_i       (done_o),
        .scal_rd_i    (scal_rd_i),
        .scal_adr_i   (scal_adr_i),
        .scal_dat_i   (scal_dat_o),
        .test_num_i   (test_num),
        .test_end_i   (test_end),
        .tests_pass_o (tests_pass),
        .tests_fail_o (tests_fail),
        .err_total_o  (err_total)
    );

    initial begin
        ifclk = 1'b0;
        forever #2 ifclk = ~ifclk;
    end

    task automatic drive_random(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge ifclk);
            count_i <= `BS_NCHAN'($random(seed));
        end
    endtask

    task automatic hold_count(input logic [`BS_NCHAN-1:0] pattern, input int n);
        @(posedge ifclk);
        count_i <= pattern;
        repeat (n - 1) @(posedge ifclk);
    endtask

    // one-cycle timer pulse out of IDLE, no done follows it
    task automatic open_interval();
        @(posedge ifclk);
        timer_i <= 1'b1;
        @(posedge ifclk);
        timer_i <= 1'b0;
    endtask

    // one-cycle timer pulse, then wait for done with a short limit
    task automatic close_interval();
        logic seen;
        seen = 1'b0;
        @(posedge ifclk);
        timer_i <= 1'b1;
        @(posedge ifclk);
        timer_i <= 1'b0;
        for (int n = 0; n < 8 && !seen; n++) begin
            @(posedge ifclk);
            seen = done_o;
        end
        if (!seen) begin
            $display("done_o never pulsed after a timer pulse in test %0d", test_num);
            tb_errs++;
        end
    endtask

    task automatic read_word(input logic [`BS_ADR_W-1:0] adr);
        @(posedge ifclk);
        scal_rd_i  <= 1'b1;
        scal_adr_i <= adr;
    endtask

    task automatic read_idle();
        @(posedge ifclk);
        scal_rd_i <= 1'b0;
    endtask

    task automatic read_all();
        for (int b = 0; b < `BS_NBEAMS; b++) read_word(b);
        read_word(`BS_STATUS_ADR);
        read_idle();
    endtask

    task automatic start_test(input logic [3:0] n);
        @(posedge ifclk);
        test_num <= n;
    endtask

    task automatic end_test();
        repeat (4) @(posedge ifclk);   // let the last read land
        test_end <= 1'b1;
        @(posedge ifclk);
        test_end <= 1'b0;
    endtask

    initial begin
        arst_n_i   = 1'b0;
        count_i    = '0;
        timer_i    = 1'b0;
        scal_rd_i  = 1'b0;
        scal_adr_i = '0;
        test_num   = '0;
        test_end   = 1'b0;
        tb_errs    = 0;
        seed       = 21;
        repeat (5) @(posedge ifclk);
        arst_n_i <= 1'b1;

        start_test(1);
        drive_random(40);   // must not show up anywhere
        open_interval();    // opens the first interval from IDLE
        hold_count('0, 30);
        close_interval();
        read_all();
        end_test();

        start_test(2);
        drive_random(100 + {$random(seed)} % 500);
        close_interval();
        read_all();
        end_test();

        start_test(3);
        for (int k = 0; k < 4; k++) begin
            drive_random(5 + {$random(seed)} % 60);
            close_interval();
            read_word(`BS_STATUS_ADR);
            read_idle();
        end
        end_test();

        start_test(4);
        hold_count(`BS_NCHAN'('h555), 300);
        close_interval();
        drive_random(150);   // second interval right behind the first
        close_interval();
        read_all();
        end_test();

        start_test(5);
        hold_count(`BS_NCHAN'(1) << ({$random(seed)} % `BS_NCHAN), SAT_HOLD_CYCLES);
        close_interval();
        read_all();
        hold_count('0, 20);
        close_interval();
        read_word(`BS_STATUS_ADR);   // flag should be gone
        read_idle();
        end_test();

        start_test(6);
        for (int a = `BS_NBEAMS; a < `BS_STATUS_ADR; a++) read_word(a);
        read_idle();
        read_all();
        end_test();

        repeat (4) @(posedge ifclk);
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_pass, tests_fail, err_total + tb_errs);
        if (tests_fail == 0 && err_total == 0 && tb_errs == 0 && tests_pass == 6) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // run limit
    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge ifclk);
            cycles++;
        end
        $display("run stopped after %0d cycles without finishing the tests", cycles);
        $display("*** FAILED ***");
        $finish;
    end

endmodule
